// File: compile.f
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_hazard_unit.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/rv_core.sv
test/rv_core_properties.sv
test/rv_core_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = rv_core_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Testbench failed
PASS_MSG  = Testbench passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/rv_core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core_tb;

    localparam int MEM_WORDS     = 64;
    localparam int NUM_STORES    = 10;
    localparam int STORE_TIMEOUT = 200;
    localparam int QUIET_CYCLES  = 40;

    // one data-port write as observed or expected
    typedef struct packed {
        logic [29:0] addr;
        logic [31:0] data;
    } store_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        imem_ren;
    logic [29:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        imem_stall;
    logic        dmem_ren;
    logic        dmem_wen;
    logic [29:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_stall;
    logic [31:0] pc;

    logic [31:0] rom [MEM_WORDS];
    logic [31:0] ram [MEM_WORDS];
    store_t      seen_q [$];
    store_t      exp_store [NUM_STORES];
    string       exp_name [NUM_STORES];
    logic [31:0] rng_state;
    logic        stall_en;
    int          pass_cnt;
    int          fail_cnt;

    rv_core DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_ren   (imem_ren),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_stall (imem_stall),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_stall (dmem_stall),
        .pc         (pc)
    );

    always #20 clk = ~clk;

    // both memories answer in the same cycle
    assign imem_rdata = rom[imem_addr[5:0]];
    assign dmem_rdata = ram[dmem_addr[5:0]];

    // a write is taken on the edge where stall is low
    always @(posedge clk) begin
        if (rst_n && dmem_wen && !dmem_stall) begin
            ram[dmem_addr[5:0]] <= dmem_wdata;
            seen_q.push_back({dmem_addr, dmem_wdata});
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // RV32I instruction encoders
    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic load_program();
        // spare words are ADDI x0 with the word index as immediate
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = enc_i(i, 0, 0, 0, 'h13);
        end
        rom[0]  = enc_i(25, 0, 0, 1, 'h13);
        rom[1]  = {20'h12345, 5'd2, 7'h37};
        rom[2]  = enc_i(-7, 0, 0, 3, 'h13);
        rom[3]  = enc_r(0, 2, 1, 0, 4);
        rom[4]  = enc_s(0, 4, 0);
        rom[5]  = enc_r('h20, 3, 1, 0, 5);
        rom[6]  = enc_s(4, 5, 0);
        rom[7]  = enc_r(0, 3, 4, 7, 6);
        rom[8]  = enc_s(8, 6, 0);
        rom[9]  = enc_r(0, 3, 1, 6, 7);
        rom[10] = enc_s(12, 7, 0);
        rom[11] = enc_r(0, 3, 4, 4, 8);
        rom[12] = enc_s(16, 8, 0);
        rom[13] = enc_r(0, 1, 3, 2, 9);
        rom[14] = enc_s(20, 9, 0);
        // dependent adds at distance one and two
        rom[15] = enc_r(0, 1, 1, 0, 10);
        rom[16] = enc_r(0, 1, 10, 0, 11);
        rom[17] = enc_r(0, 11, 10, 0, 12);
        rom[18] = enc_s(24, 12, 0);
        rom[19] = enc_i(0, 0, 2, 13, 'h03);
        rom[20] = enc_r(0, 1, 13, 0, 14);
        rom[21] = enc_s(28, 14, 0);
        // word 15 is written only by skipped stores
        rom[22] = enc_b(8, 1, 1, 0);
        rom[23] = enc_s(60, 1, 0);
        rom[24] = enc_b(8, 3, 1, 1);
        rom[25] = enc_s(60, 1, 0);
        rom[26] = enc_b(8, 3, 1, 0);
        rom[27] = enc_s(32, 3, 0);
        rom[28] = enc_j(8, 15);
        rom[29] = enc_s(60, 1, 0);
        rom[30] = enc_s(36, 15, 0);
        rom[31] = enc_j(0, 0);
    endtask

    task automatic set_expect(input int i, input string name, input int word,
                              input logic [31:0] data);
        exp_name[i]       = name;
        exp_store[i].addr = word[29:0];
        exp_store[i].data = data;
    endtask

    task automatic build_expect();
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        logic [31:0] x4;
        logic [31:0] x10;
        logic [31:0] x11;
        x1  = 32'd25;
        x2  = {20'h12345, 12'h000};
        x3  = -32'sd7;
        x4  = x1 + x2;
        x10 = x1 + x1;
        x11 = x10 + x1;
        set_expect(0, "add", 0, x4);
        set_expect(1, "sub", 1, x1 - x3);
        set_expect(2, "and", 2, x4 & x3);
        set_expect(3, "or", 3, x1 | x3);
        set_expect(4, "xor", 4, x4 ^ x3);
        set_expect(5, "slt", 5, ($signed(x3) < $signed(x1)) ? 32'd1 : 32'd0);
        set_expect(6, "forward", 6, x10 + x11);
        set_expect(7, "load_use", 7, x4 + x1);
        set_expect(8, "branch_fallthrough", 8, x3);
        // link of the JAL at word 28
        set_expect(9, "jal_link", 9, 32'd28 * 4 + 4);
    endtask

    // stalls change only on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        if (stall_en) begin
            rng_state  = xorshift(rng_state);
            imem_stall = rng_state[0] & rng_state[1];
            dmem_stall = rng_state[4] & rng_state[5];
        end else begin
            imem_stall = 1'b0;
            dmem_stall = 1'b0;
        end
    endtask

    task automatic check_level(input string name, input logic exp,
                               input logic act, output logic ok);
        ok = (act === exp);
        if (!ok) begin
            $display("FAIL %s: request expected %b, actual %b", name, exp, act);
            fail_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input logic [29:0] exp,
                              input logic [29:0] act, output logic ok);
        ok = (act === exp);
        if (!ok) begin
            $display("FAIL %s: word address expected %0h, actual %0h", name, exp, act);
            fail_cnt++;
        end
    endtask

    task automatic check_data(input string name, input logic [31:0] exp,
                              input logic [31:0] act, output logic ok);
        ok = (act === exp);
        if (!ok) begin
            $display("FAIL %s: data expected %h, actual %h", name, exp, act);
            fail_cnt++;
        end
    endtask

    task automatic run_pass(input string tag, input logic stalls);
        store_t got;
        string  name;
        int     waited;
        logic   ok;
        stall_en = 1'b0;
        rst_n    = 1'b0;
        repeat (2) next_cycle();
        // no instruction request while reset is held
        name = $sformatf("%s_fetch_start", tag);
        check_level(name, 1'b0, imem_ren, ok);
        seen_q.delete();
        rst_n    = 1'b1;
        stall_en = stalls;
        // first request one cycle after release, from the reset address
        next_cycle();
        if (ok) begin
            check_level(name, 1'b1, imem_ren, ok);
        end
        if (ok) begin
            check_addr(name, 30'h0, imem_addr, ok);
        end
        if (ok) begin
            $display("PASS %s: fetch request at word %0h", name, imem_addr);
            pass_cnt++;
        end
        for (int i = 0; i < NUM_STORES; i++) begin
            name   = $sformatf("%s_%s", tag, exp_name[i]);
            waited = 0;
            while (seen_q.size() == 0 && waited < STORE_TIMEOUT) begin
                next_cycle();
                waited++;
            end
            if (seen_q.size() == 0) begin
                $display("FAIL %s: no store seen before timeout", name);
                fail_cnt++;
                return;
            end
            got = seen_q.pop_front();
            check_addr(name, exp_store[i].addr, got.addr, ok);
            if (ok) begin
                check_data(name, exp_store[i].data, got.data, ok);
            end
            if (ok) begin
                $display("PASS %s: word %0h data %h", name, got.addr, got.data);
                pass_cnt++;
            end
        end
        // the program now spins on its last JAL
        repeat (QUIET_CYCLES) next_cycle();
        if (seen_q.size() != 0) begin
            $display("FAIL %s_no_extra: %0d store(s) after the last expected one",
                     tag, seen_q.size());
            fail_cnt++;
        end else begin
            $display("PASS %s_no_extra: no further stores", tag);
            pass_cnt++;
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        imem_stall = 1'b0;
        dmem_stall = 1'b0;
        stall_en   = 1'b0;
        rng_state  = 32'hb123;
        pass_cnt   = 0;
        fail_cnt   = 0;
        load_program();
        build_expect();
        run_pass("clean", 1'b0);
        run_pass("stalled", 1'b1);
        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/rv_core_properties.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core_properties (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        dmem_ren,
    input  logic        dmem_wen,
    input  logic [29:0] dmem_addr,
    input  logic [31:0] dmem_wdata,
    input  logic        dmem_stall,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic [31:0] pc
);

    // one access kind at a time
    no_read_and_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_ren && dmem_wen))
        else $error("data port read and write high together");

    quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> (!dmem_ren && !dmem_wen))
        else $error("data port request in the cycle after reset");

    // a stalled request must not move
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_stall && (dmem_ren || dmem_wen)) |=>
        ($stable(dmem_ren) && $stable(dmem_wen) &&
         $stable(dmem_addr) && $stable(dmem_wdata)))
        else $error("data port request changed while stalled");

    redirect_loads_pc: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> (pc == $past(redirect_pc)))
        else $error("pc differs from redirect target");

endmodule

bind rv_core rv_core_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .dmem_ren    (dmem_ren),
    .dmem_wen    (dmem_wen),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_stall  (dmem_stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (pc)
);

`default_nettype wire

// File: hdl/rv_core.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    output logic        imem_ren,
    output logic [29:0] imem_addr,
    input  logic [31:0] imem_rdata,
    input  logic        imem_stall,
    output logic        dmem_ren,
    output logic        dmem_wen,
    output logic [29:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    input  logic [31:0] dmem_rdata,
    input  logic        dmem_stall,
    output logic [31:0] pc
);

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    logic        load_use;
    logic        freeze;
    logic        ex_redirect;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [31:0] ex_mem_fwd;
    logic        fetch_hold;
    logic        decode_bubble;

    // a redirect waits until the data port releases the pipeline
    assign redirect      = ex_redirect && !freeze;
    assign fetch_hold    = freeze || load_use;
    assign decode_bubble = load_use || redirect;

    // JAL's result is its link address
    assign ex_mem_fwd = ex_mem.is_jal ? ex_mem.link_pc : ex_mem.alu_result;

    rv_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (fetch_hold),
        .flush       (redirect),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_ren    (imem_ren),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .imem_stall  (imem_stall),
        .pc          (pc),
        .if_id       (if_id)
    );

    rv_decode u_decode (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (freeze),
        .bubble (decode_bubble),
        .if_id  (if_id),
        .wb     (mem_wb),
        .rs1    (rs1),
        .rs2    (rs2),
        .id_ex  (id_ex)
    );

    rv_hazard_unit u_hazard (
        .rs1      (rs1),
        .rs2      (rs2),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .load_use (load_use)
    );

    rv_execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (freeze),
        .id_ex       (id_ex),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .ex_mem_fwd  (ex_mem_fwd),
        .mem_wb_fwd  (mem_wb.wb_data),
        .redirect    (ex_redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    rv_memory u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_stall (dmem_stall),
        .freeze     (freeze),
        .mem_wb     (mem_wb)
    );

endmodule

`default_nettype wire

// File: hdl/rv_memory.sv
`default_nettype none
`timescale 1ns/1ps

module rv_memory import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  ex_mem_t     ex_mem,
    output logic        dmem_ren,
    output logic        dmem_wen,
    output logic [29:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    input  logic [31:0] dmem_rdata,
    input  logic        dmem_stall,
    output logic        freeze,
    output mem_wb_t     mem_wb
);

    logic [31:0] wb_data;

    assign dmem_ren   = ex_mem.valid && ex_mem.mem_read;
    assign dmem_wen   = ex_mem.valid && ex_mem.mem_write;
    assign dmem_addr  = ex_mem.alu_result[31:2];
    assign dmem_wdata = ex_mem.store_data;

    // pending access not yet accepted
    assign freeze = (dmem_ren || dmem_wen) && dmem_stall;

    assign wb_data = ex_mem.mem_read ? dmem_rdata :
                     ex_mem.is_jal   ? ex_mem.link_pc : ex_mem.alu_result;

    // payload holds while frozen so forwarding into EX stays correct
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.valid     <= 1'b0;
            mem_wb.reg_write <= 1'b0;
        end else begin
            mem_wb.valid <= ex_mem.valid && !freeze;
            if (!freeze) begin
                mem_wb.rd        <= ex_mem.rd;
                mem_wb.wb_data   <= wb_data;
                mem_wb.reg_write <= ex_mem.reg_write;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_execute.sv
`default_nettype none
`timescale 1ns/1ps

module rv_execute import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hold,
    input  id_ex_t      id_ex,
    input  fwd_sel_e    fwd_a,
    input  fwd_sel_e    fwd_b,
    input  logic [31:0] ex_mem_fwd,
    input  logic [31:0] mem_wb_fwd,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output ex_mem_t     ex_mem
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        taken;

    function automatic logic [31:0] fwd_mux(
        input fwd_sel_e    sel,
        input logic [31:0] reg_val,
        input logic [31:0] em_val,
        input logic [31:0] wb_val
    );
        case (sel)
            FWD_EX_MEM: return em_val;
            FWD_MEM_WB: return wb_val;
            default:    return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem_fwd, mem_wb_fwd);
    assign op_b  = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem_fwd, mem_wb_fwd);
    assign alu_b = id_ex.alu_src_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_result = op_a + alu_b;
            ALU_SUB:    alu_result = op_a - alu_b;
            ALU_AND:    alu_result = op_a & alu_b;
            ALU_OR:     alu_result = op_a | alu_b;
            ALU_XOR:    alu_result = op_a ^ alu_b;
            ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(alu_b)};
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = '0;
        endcase
    end

    // BEQ when equal, BNE when not
    assign taken       = id_ex.is_branch && ((op_a == op_b) != id_ex.branch_ne);
    assign redirect    = id_ex.valid && (taken || id_ex.is_jal);
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
        end else if (!hold) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= op_b;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.link_pc    <= id_ex.pc + 32'd4;
            ex_mem.mem_read   <= id_ex.valid && id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.valid && id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.valid && id_ex.reg_write;
            ex_mem.is_jal     <= id_ex.is_jal;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_hazard_unit.sv
`default_nettype none
`timescale 1ns/1ps

module rv_hazard_unit import rv_core_pkg::*; (
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  id_ex_t     id_ex,
    input  ex_mem_t    ex_mem,
    input  mem_wb_t    mem_wb,
    output fwd_sel_e   fwd_a,
    output fwd_sel_e   fwd_b,
    output logic       load_use
);

    // younger result wins, x0 never forwarded
    // reg_write is already cleared for bubbles upstream; mem_wb.valid drops
    // during a data stall while its payload is still the live value
    function automatic fwd_sel_e pick_src(
        input logic [4:0] rs,
        input ex_mem_t    em,
        input mem_wb_t    mw
    );
        if (rs == 5'd0) begin
            return FWD_NONE;
        end
        if (em.reg_write && em.rd == rs) begin
            return FWD_EX_MEM;
        end
        if (mw.reg_write && mw.rd == rs) begin
            return FWD_MEM_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a = pick_src(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = pick_src(id_ex.rs2, ex_mem, mem_wb);

    // load in EX feeding the instruction in ID
    assign load_use = id_ex.valid && id_ex.mem_read && (id_ex.rd != 5'd0) &&
                      ((id_ex.rd == rs1) || (id_ex.rd == rs2));

endmodule

`default_nettype wire

// File: hdl/rv_decode.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_core_defs.svh"

module rv_decode import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hold,
    input  logic       bubble,
    input  if_id_t     if_id,
    input  mem_wb_t    wb,
    output logic [4:0] rs1,
    output logic [4:0] rs2,
    output id_ex_t     id_ex
);

    instr_u            ins;
    id_ex_t            dec;
    logic              supported;
    logic              use_rs1;
    logic              use_rs2;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign ins = if_id.instr;

    // immediates, one per format
    assign imm_i = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
    assign imm_s = {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
    assign imm_b = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                    ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {ins.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{ins.j_fmt.imm_20}}, ins.j_fmt.imm_20, ins.j_fmt.imm_19_12,
                    ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        supported = 1'b1;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        dec       = '0;
        dec.pc    = if_id.pc;
        dec.rd    = ins.r_fmt.rd;
        case (ins.r_fmt.opcode)
            OPC_OP: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                dec.reg_write = 1'b1;
                case (ins.r_fmt.funct3)
                    3'b000:  dec.alu_op = ins.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                use_rs1         = 1'b1;
                supported       = (ins.i_fmt.funct3 == 3'b000);
                dec.imm         = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_LUI: begin
                dec.imm         = imm_u;
                dec.alu_op      = ALU_PASS_B;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_LOAD: begin
                use_rs1         = 1'b1;
                supported       = (ins.i_fmt.funct3 == 3'b010);
                dec.imm         = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.mem_read    = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_STORE: begin
                use_rs1         = 1'b1;
                use_rs2         = 1'b1;
                supported       = (ins.s_fmt.funct3 == 3'b010);
                dec.imm         = imm_s;
                dec.alu_src_imm = 1'b1;
                dec.mem_write   = 1'b1;
            end
            OPC_BRANCH: begin
                // BEQ and BNE
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                supported     = (ins.b_fmt.funct3[2:1] == 2'b00);
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = ins.b_fmt.funct3[0];
            end
            OPC_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: supported = 1'b0;
        endcase
        // unused sources read as x0 so they never forward or stall
        rs1       = (if_id.valid && use_rs1) ? ins.r_fmt.rs1 : 5'd0;
        rs2       = (if_id.valid && use_rs2) ? ins.r_fmt.rs2 : 5'd0;
        dec.rs1   = rs1;
        dec.rs2   = rs2;
        dec.valid = if_id.valid && supported;
    end

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else if (!hold) begin
            id_ex          <= dec;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.valid    <= dec.valid && !bubble;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_core_defs.svh"

module rv_regfile import rv_core_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data,
    input  mem_wb_t           wb
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic              wb_hit;
    logic              wr_en;

    // x0 is never written
    assign wb_hit = wb.valid && wb.reg_write && (wb.rd != 5'd0);
    assign wr_en  = rst_n && wb_hit;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb.rd] <= wb.wb_data;
        end
    end

    // write-through so decode sees the value retiring now
    assign rs1_data = (rs1 == 5'd0) ? '0 :
                      (wb_hit && wb.rd == rs1) ? wb.wb_data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 :
                      (wb_hit && wb.rd == rs2) ? wb.wb_data : regs[rs2];

endmodule

`default_nettype wire

// File: hdl/rv_fetch.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_core_defs.svh"

module rv_fetch import rv_core_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hold,
    input  logic              flush,
    input  logic              redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    output logic              imem_ren,
    output logic [29:0]       imem_addr,
    input  logic [`XLEN-1:0] imem_rdata,
    input  logic              imem_stall,
    output logic [`XLEN-1:0] pc,
    output if_id_t            if_id
);

    logic fetch_en;
    logic fetch_ok;

    assign imem_ren  = fetch_en;
    assign imem_addr = pc[`XLEN-1:2];

    // word returned this cycle
    assign fetch_ok = imem_ren && !imem_stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_en <= 1'b0;
            pc       <= `RESET_PC;
        end else begin
            fetch_en <= 1'b1;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (fetch_ok && !hold) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // a stalled fetch leaves a bubble behind
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id.valid <= 1'b0;
        end else if (flush) begin
            if_id.valid <= 1'b0;
        end else if (!hold) begin
            if_id.valid <= fetch_ok;
            if_id.pc    <= pc;
            if_id.instr <= imem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_core_pkg.sv
`default_nettype none

`include "rv_core_defs.svh"

package rv_core_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // operand source seen by execute
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one instruction word, six readings
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0] pc;
        instr_u            instr;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0] pc;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic [`XLEN-1:0] imm;
        alu_op_e           alu_op;
        logic              alu_src_imm;
        logic              is_branch;
        logic              branch_ne;
        logic              is_jal;
        logic              mem_read;
        logic              mem_write;
        logic              reg_write;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] store_data;
        logic [4:0]        rd;
        logic [`XLEN-1:0] link_pc;
        logic              mem_read;
        logic              mem_write;
        logic              reg_write;
        logic              is_jal;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        logic [4:0]        rd;
        logic [`XLEN-1:0] wb_data;
        logic              reg_write;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: hdl/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath and address width
`define XLEN 32

// byte address of the first fetch
`define RESET_PC 32'h0000_0000

// architectural integer registers
`define NUM_REGS 32

`endif
